/* Bender.yml */
package:
  name: scene_path

sources:
  - source/mem_pkg.sv
  - source/pixel_pkg.sv
  - source/scene_loader.sv
  - source/memory_request_arbiter.sv
  - source/scene_retriever.sv
  - source/fifo.sv
  - source/frame_buffer_handler.sv
  - source/scene_top.sv
  - target: test
    files:
      - test/scene_chk.sv
      - test/scene_tb.sv

/* list.f */
source/mem_pkg.sv
source/pixel_pkg.sv
source/scene_loader.sv
source/memory_request_arbiter.sv
source/scene_retriever.sv
source/fifo.sv
source/frame_buffer_handler.sv
source/scene_top.sv
test/scene_chk.sv
test/scene_tb.sv

/* source/fifo.sv */
`default_nettype none

module fifo #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 16
) (
    input  logic             clk,
    input  logic             reset,
    input  logic [WIDTH-1:0] data_in,
    input  logic             we,
    input  logic             re,
    output logic             full,
    output logic             empty,
    output logic [WIDTH-1:0] data_out
);
    import mem_pkg::*;

    logic [WIDTH-1:0]           buffer [DEPTH];
    logic [$clog2(DEPTH)-1:0]   wr_ptr;
    logic [$clog2(DEPTH)-1:0]   rd_ptr;
    logic [$clog2(DEPTH+1)-1:0] count;
    logic                       do_push;
    logic                       do_pop;

    // Early full leaves room for one whole burst
    assign full     = (count >= DEPTH - MAX_TRANS);
    assign empty    = (count == '0);
    assign data_out = buffer[rd_ptr];

    assign do_push = we && (count != DEPTH);
    assign do_pop  = re && !empty;

    always_ff @(posedge clk) begin
        if (do_push) begin
            buffer[wr_ptr] <= data_in;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* source/frame_buffer_handler.sv */
`default_nettype none

module frame_buffer_handler (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           pb_empty,
    input  pixel_pkg::pixel_buffer_entry_t pb_data_out,
    input  logic                           fb_ready,
    output logic                           pb_re,
    output logic                           fb_we,
    output pixel_pkg::fb_addr_t            fb_addr,
    output pixel_pkg::pixel_color_t        fb_color,
    output logic                           frame_done
);
    import mem_pkg::*;
    import pixel_pkg::*;

    hdl_state_t state;
    mem_addr_t  wr_count;

    // Entry is already on pb_data_out in the cycle it is popped
    assign pb_re = (state == HDL_IDLE) && !pb_empty && !frame_done;

    always_ff @(posedge clk) begin
        if (pb_re) begin
            fb_addr  <= fb_addr_t'(pb_data_out.y * FB_WIDTH + pb_data_out.x);
            fb_color <= pb_data_out.color;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= HDL_IDLE;
            fb_we      <= 1'b0;
            wr_count   <= '0;
            frame_done <= 1'b0;
        end else begin
            case (state)
                HDL_IDLE: begin
                    if (pb_re) begin
                        fb_we <= 1'b1;
                        state <= HDL_WRITE;
                    end
                end
                HDL_WRITE: begin
                    // Hold address and color until the frame buffer takes them
                    if (fb_ready) begin
                        fb_we    <= 1'b0;
                        wr_count <= wr_count + 1'b1;
                        state    <= HDL_IDLE;
                        if (wr_count == mem_addr_t'(SCENE_WORDS - 1)) begin
                            frame_done <= 1'b1;
                        end
                    end
                end
                default: begin
                    state <= HDL_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/mem_pkg.sv */
`default_nettype none

package mem_pkg;

    // Scene memory geometry
    localparam int MEM_ADDR_W  = 6;
    localparam int SCENE_WORDS = 32;

    // Longest read burst in words
    localparam int MAX_TRANS = 8;

    typedef logic [MEM_ADDR_W-1:0] mem_addr_t;
    typedef logic [31:0] mem_word_t;

    // Must hold MAX_TRANS itself, not only MAX_TRANS-1
    typedef logic [$clog2(MAX_TRANS+1)-1:0] trans_size_t;

    typedef enum logic [1:0] {
        MEM_IDLE,
        MEM_WRITE,
        MEM_READ
    } mem_op_t;

endpackage

`default_nettype wire

/* source/memory_request_arbiter.sv */
`default_nettype none

module memory_request_arbiter (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 write_req,
    input  mem_pkg::mem_addr_t   write_addr,
    input  mem_pkg::mem_word_t   write_data,
    input  logic                 read_req,
    input  mem_pkg::mem_addr_t   read_addr,
    input  mem_pkg::trans_size_t read_size,
    output logic                 write_done,
    output logic                 read_valid,
    output mem_pkg::mem_word_t   read_data,
    output logic                 read_done
);
    import mem_pkg::*;

    mem_op_t     op;
    logic        prefer_read;
    logic        rd_run;
    logic        rd_fire;
    mem_addr_t   rd_addr;
    trans_size_t rd_cnt;

    // Stand-in for the SDRAM
    mem_word_t mem [2**MEM_ADDR_W];

    // The write completes in its grant cycle
    assign write_done = (op == MEM_WRITE);

    // First MEM_READ cycle only loads the burst counters
    assign rd_fire = (op == MEM_READ) && rd_run;

    always_ff @(posedge clk) begin
        if (reset) begin
            op          <= MEM_IDLE;
            prefer_read <= 1'b0;
            rd_run      <= 1'b0;
            rd_addr     <= '0;
            rd_cnt      <= '0;
            read_valid  <= 1'b0;
            read_done   <= 1'b0;
        end else begin
            read_valid <= rd_fire;
            read_done  <= rd_fire && (rd_cnt == trans_size_t'(1));
            case (op)
                MEM_IDLE: begin
                    // Round-robin where the last winner yields on a tie
                    if (write_req && (!read_req || !prefer_read)) begin
                        op          <= MEM_WRITE;
                        prefer_read <= 1'b1;
                    end else if (read_req) begin
                        op          <= MEM_READ;
                        prefer_read <= 1'b0;
                    end
                end
                MEM_WRITE: begin
                    op <= MEM_IDLE;
                end
                MEM_READ: begin
                    if (!rd_run) begin
                        rd_run  <= 1'b1;
                        rd_addr <= read_addr;
                        rd_cnt  <= read_size;
                    end else begin
                        rd_addr <= rd_addr + 1'b1;
                        rd_cnt  <= rd_cnt - 1'b1;
                        if (rd_cnt == trans_size_t'(1)) begin
                            rd_run <= 1'b0;
                            op     <= MEM_IDLE;
                        end
                    end
                end
                default: begin
                    op <= MEM_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (write_done) begin
            mem[write_addr] <= write_data;
        end
        if (rd_fire) begin
            read_data <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

/* source/pixel_pkg.sv */
`default_nettype none

package pixel_pkg;

    localparam int FB_WIDTH   = 160;
    localparam int FB_HEIGHT  = 120;
    localparam int FIFO_DEPTH = 16;

    // RGB565
    typedef logic [15:0] pixel_color_t;

    // Linear address y * FB_WIDTH + x
    typedef logic [14:0] fb_addr_t;

    typedef struct packed {
        logic [7:0]   x;
        logic [7:0]   y;
        pixel_color_t color;
    } pixel_buffer_entry_t;

    typedef enum logic {
        HDL_IDLE,
        HDL_WRITE
    } hdl_state_t;

endpackage

`default_nettype wire

/* source/scene_loader.sv */
`default_nettype none

module scene_loader (
    input  logic               clk,
    input  logic               reset,
    input  logic               byte_valid,
    input  logic [7:0]         byte_data,
    input  logic               write_done,
    output logic               write_req,
    output mem_pkg::mem_addr_t write_addr,
    output mem_pkg::mem_word_t write_data,
    output logic               scene_loaded
);
    import mem_pkg::*;

    logic [1:0]  byte_cnt;
    logic [23:0] byte_buf;
    logic        all_words;
    logic        take_byte;

    // Bytes after the last word of the scene are dropped
    assign take_byte = byte_valid && !all_words;

    // First byte lands in bits 7:0
    always_ff @(posedge clk) begin
        if (take_byte) begin
            if (byte_cnt == 2'd3) begin
                write_data <= {byte_data, byte_buf};
            end else begin
                byte_buf <= {byte_data, byte_buf[23:8]};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            byte_cnt     <= '0;
            write_req    <= 1'b0;
            write_addr   <= '0;
            all_words    <= 1'b0;
            scene_loaded <= 1'b0;
        end else begin
            if (take_byte) begin
                byte_cnt <= byte_cnt + 2'd1;
                if (byte_cnt == 2'd3) begin
                    write_req <= 1'b1;
                    if (write_addr == mem_addr_t'(SCENE_WORDS - 1)) begin
                        all_words <= 1'b1;
                    end
                end
            end
            // Request drops for at least a cycle after each done
            if (write_done) begin
                write_req  <= 1'b0;
                write_addr <= write_addr + 1'b1;
                if (write_addr == mem_addr_t'(SCENE_WORDS - 1)) begin
                    scene_loaded <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* source/scene_retriever.sv */
`default_nettype none

module scene_retriever (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           scene_loaded,
    input  logic                           read_valid,
    input  mem_pkg::mem_word_t             read_data,
    input  logic                           read_done,
    input  logic                           pb_full,
    output logic                           read_req,
    output mem_pkg::mem_addr_t             read_addr,
    output mem_pkg::trans_size_t           read_size,
    output logic                           pb_we,
    output pixel_pkg::pixel_buffer_entry_t pb_data_in
);
    import mem_pkg::*;
    import pixel_pkg::*;

    logic      in_burst;
    logic      all_sent;
    logic      start_burst;
    mem_addr_t burst_addr;

    assign read_addr = burst_addr;
    assign read_size = trans_size_t'(MAX_TRANS);

    // Wait out the trailing push so pb_full counts it
    assign start_burst = scene_loaded && !all_sent && !in_burst && !pb_we && !pb_full;

    always_ff @(posedge clk) begin
        if (reset) begin
            read_req   <= 1'b0;
            in_burst   <= 1'b0;
            all_sent   <= 1'b0;
            burst_addr <= '0;
            pb_we      <= 1'b0;
        end else begin
            pb_we <= read_valid;
            if (start_burst) begin
                read_req <= 1'b1;
                in_burst <= 1'b1;
            end
            if (read_valid) begin
                read_req <= 1'b0;
            end
            if (read_done) begin
                in_burst   <= 1'b0;
                burst_addr <= burst_addr + mem_addr_t'(MAX_TRANS);
                if (burst_addr == mem_addr_t'(SCENE_WORDS - MAX_TRANS)) begin
                    all_sent <= 1'b1;
                end
            end
        end
    end

    // Color in 31:16, y in 15:8 and x in 7:0
    always_ff @(posedge clk) begin
        if (read_valid) begin
            pb_data_in.x     <= 8'(read_data[7:0] % FB_WIDTH);
            pb_data_in.y     <= 8'(read_data[15:8] % FB_HEIGHT);
            pb_data_in.color <= read_data[31:16];
        end
    end

endmodule

`default_nettype wire

/* source/scene_top.sv */
`default_nettype none

module scene_top (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    byte_valid,
    input  logic [7:0]              byte_data,
    input  logic                    fb_ready,
    output logic                    fb_we,
    output pixel_pkg::fb_addr_t     fb_addr,
    output pixel_pkg::pixel_color_t fb_color,
    output logic                    scene_loaded,
    output logic                    frame_done
);
    import mem_pkg::*;
    import pixel_pkg::*;

    // Write port
    logic      write_req;
    logic      write_done;
    mem_addr_t write_addr;
    mem_word_t write_data;

    // Read port
    logic        read_req;
    logic        read_valid;
    logic        read_done;
    mem_addr_t   read_addr;
    trans_size_t read_size;
    mem_word_t   read_data;

    // Pixel buffer
    logic                pb_we;
    logic                pb_re;
    logic                pb_full;
    logic                pb_empty;
    pixel_buffer_entry_t pb_data_in;
    pixel_buffer_entry_t pb_data_out;

    scene_loader sl (
        .clk, .reset, .byte_valid, .byte_data, .write_done,
        .write_req, .write_addr, .write_data, .scene_loaded
    );

    memory_request_arbiter mra (
        .clk, .reset, .write_req, .write_addr, .write_data,
        .read_req, .read_addr, .read_size,
        .write_done, .read_valid, .read_data, .read_done
    );

    scene_retriever sr (
        .clk, .reset, .scene_loaded, .read_valid, .read_data, .read_done, .pb_full,
        .read_req, .read_addr, .read_size, .pb_we, .pb_data_in
    );

    fifo #(.WIDTH($bits(pixel_buffer_entry_t)), .DEPTH(FIFO_DEPTH)) pb (
        .clk,
        .reset,
        .data_in(pb_data_in),
        .we(pb_we),
        .re(pb_re),
        .full(pb_full),
        .empty(pb_empty),
        .data_out(pb_data_out)
    );

    frame_buffer_handler fbh (
        .clk, .reset, .pb_empty, .pb_data_out, .fb_ready,
        .pb_re, .fb_we, .fb_addr, .fb_color, .frame_done
    );

endmodule

`default_nettype wire

/* test/scene_chk.sv */
`default_nettype none

module scene_chk (
    input logic                    clk,
    input logic                    reset,
    input logic                    write_done,
    input logic                    read_valid,
    input logic                    push,
    input logic                    pop,
    input logic                    at_capacity,
    input logic                    empty,
    input logic                    fb_we,
    input logic                    fb_ready,
    input pixel_pkg::fb_addr_t     fb_addr,
    input pixel_pkg::pixel_color_t fb_color
);
    int err_count = 0;

    // One memory port active per cycle
    a_one_port: assert property (@(posedge clk) disable iff (reset)
        !(write_done && read_valid))
        else begin
            $error("write_done and read_valid high in the same cycle");
            err_count++;
        end

    a_no_overflow: assert property (@(posedge clk) disable iff (reset)
        !(push && at_capacity))
        else begin
            $error("push into a FIFO that holds DEPTH entries");
            err_count++;
        end

    a_no_underflow: assert property (@(posedge clk) disable iff (reset)
        !(pop && empty))
        else begin
            $error("pop from an empty FIFO");
            err_count++;
        end

    // Stalled write keeps its address and color
    a_hold_write: assert property (@(posedge clk) disable iff (reset)
        (fb_we && !fb_ready) |=> (fb_we && $stable(fb_addr) && $stable(fb_color)))
        else begin
            $error("frame buffer write changed while stalled");
            err_count++;
        end

endmodule

bind memory_request_arbiter scene_chk arb_chk (
    .clk(clk),
    .reset(reset),
    .write_done(write_done),
    .read_valid(read_valid),
    .push(1'b0),
    .pop(1'b0),
    .at_capacity(1'b0),
    .empty(1'b0),
    .fb_we(1'b0),
    .fb_ready(1'b0),
    .fb_addr(15'd0),
    .fb_color(16'd0)
);

bind fifo scene_chk pb_chk (
    .clk(clk),
    .reset(reset),
    .write_done(1'b0),
    .read_valid(1'b0),
    .push(we),
    .pop(re),
    .at_capacity(count == DEPTH),
    .empty(empty),
    .fb_we(1'b0),
    .fb_ready(1'b0),
    .fb_addr(15'd0),
    .fb_color(16'd0)
);

bind frame_buffer_handler scene_chk fb_chk (
    .clk(clk),
    .reset(reset),
    .write_done(1'b0),
    .read_valid(1'b0),
    .push(1'b0),
    .pop(1'b0),
    .at_capacity(1'b0),
    .empty(1'b0),
    .fb_we(fb_we),
    .fb_ready(fb_ready),
    .fb_addr(fb_addr),
    .fb_color(fb_color)
);

`default_nettype wire

/* test/scene_tb.sv */
`default_nettype none

module scene_tb;
    import mem_pkg::*;
    import pixel_pkg::*;

    logic         clk = 1'b0;
    logic         reset;
    logic         byte_valid;
    logic [7:0]   byte_data;
    logic         fb_ready;
    logic         fb_we;
    fb_addr_t     fb_addr;
    pixel_color_t fb_color;
    logic         scene_loaded;
    logic         frame_done;

    logic [15:0]  lfsr = 16'd18319;
    logic [31:0]  word_acc;
    int           byte_count;
    int           write_count;
    int           assert_errors;
    logic         bytes_done;
    fb_addr_t     exp_addr_q [$];
    pixel_color_t exp_color_q [$];

    scene_top dut (
        .clk, .reset, .byte_valid, .byte_data, .fb_ready,
        .fb_we, .fb_addr, .fb_color, .scene_loaded, .frame_done
    );

    always #5 clk = ~clk;

    // Galois LFSR with polynomial x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hB400;
        end
        return s >> 1;
    endfunction

    task automatic take_bits(input int n, output logic [7:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[6:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    function automatic fb_addr_t expected_addr(input logic [31:0] w);
        int x;
        int y;
        x = w[7:0] % FB_WIDTH;
        y = w[15:8] % FB_HEIGHT;
        return fb_addr_t'(y * FB_WIDTH + x);
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_addr(input fb_addr_t got, input fb_addr_t exp, input string what);
        if (got !== exp) begin
            stop_on_error($sformatf("FAIL at time %0t: %s expected %0d got %0d",
                $time, what, exp, got));
        end
    endtask

    task automatic check_color(input pixel_color_t got, input pixel_color_t exp,
                               input string what);
        if (got !== exp) begin
            stop_on_error($sformatf("FAIL at time %0t: %s expected %04h got %04h",
                $time, what, exp, got));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            stop_on_error($sformatf("FAIL at time %0t: %s expected %b got %b",
                $time, what, exp, got));
        end
    endtask

    // Sample outputs after the edge, then drive inputs for the next one
    task automatic next_cycle(input logic bv, input logic [7:0] bd);
        logic [7:0] r;
        @(posedge clk);
        #1;
        take_bits(2, r);
        if (!bytes_done) begin
            check_flag(scene_loaded, 1'b0, "scene_loaded before the last scene byte");
            check_flag(fb_we, 1'b0, "fb_we before the scene is loaded");
        end
        if (write_count < SCENE_WORDS) begin
            check_flag(frame_done, 1'b0, "frame_done before the last write");
        end
        // A write completes at the next edge when fb_we meets fb_ready
        if (fb_we && r[1:0] != 2'b00) begin
            if (exp_addr_q.size() == 0) begin
                stop_on_error("Frame buffer write with no scene word left to write");
            end else begin
                check_addr(fb_addr, exp_addr_q.pop_front(), "frame buffer address");
                check_color(fb_color, exp_color_q.pop_front(), "frame buffer color");
                write_count++;
            end
        end
        byte_valid = bv;
        byte_data  = bd;
        fb_ready   = (r[1:0] != 2'b00);
    endtask

    // One byte and then a gap so bytes are 4 to 7 cycles apart
    task automatic send_byte(input logic in_scene);
        logic [7:0] b;
        logic [7:0] gap;
        take_bits(8, b);
        take_bits(2, gap);
        if (in_scene) begin
            word_acc = {b, word_acc[31:8]};
            byte_count++;
            if (byte_count % 4 == 0) begin
                exp_addr_q.push_back(expected_addr(word_acc));
                exp_color_q.push_back(word_acc[31:16]);
            end
        end
        next_cycle(1'b1, b);
        if (in_scene && byte_count == 4 * SCENE_WORDS) begin
            bytes_done = 1'b1;
        end
        for (int i = 0; i < 3 + gap; i++) begin
            next_cycle(1'b0, 8'h00);
        end
    endtask

    initial begin
        reset       = 1'b1;
        byte_valid  = 1'b0;
        byte_data   = 8'h00;
        fb_ready    = 1'b0;
        word_acc    = '0;
        byte_count  = 0;
        write_count = 0;
        bytes_done  = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;

        // Quiet outputs before any byte
        for (int i = 0; i < 8; i++) begin
            next_cycle(1'b0, 8'h00);
        end

        for (int i = 0; i < 4 * SCENE_WORDS; i++) begin
            send_byte(1'b1);
        end

        for (int i = 0; !scene_loaded; i++) begin
            if (i == 20) begin
                stop_on_error("Timed out waiting for scene_loaded after the last byte");
            end else begin
                next_cycle(1'b0, 8'h00);
            end
        end

        // Bytes past the end of the scene
        for (int i = 0; i < 8; i++) begin
            send_byte(1'b0);
        end

        for (int i = 0; write_count < SCENE_WORDS; i++) begin
            if (i == 4000) begin
                stop_on_error("Timed out waiting for all frame buffer writes");
            end else begin
                next_cycle(1'b0, 8'h00);
            end
        end

        for (int i = 0; !frame_done; i++) begin
            if (i == 5) begin
                stop_on_error("Timed out waiting for frame_done after the last write");
            end else begin
                next_cycle(1'b0, 8'h00);
            end
        end

        for (int i = 0; i < 40; i++) begin
            next_cycle(1'b0, 8'h00);
            check_flag(frame_done, 1'b1, "frame_done after the frame");
            check_flag(scene_loaded, 1'b1, "scene_loaded after the frame");
            check_flag(fb_we, 1'b0, "fb_we after frame_done");
        end

        assert_errors = dut.mra.arb_chk.err_count + dut.pb.pb_chk.err_count
            + dut.fbh.fb_chk.err_count;
        if (assert_errors == 0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            $display("Test failures found");
            $fatal(1, "%0d assertion failures in the bound checkers", assert_errors);
        end
    end

endmodule

`default_nettype wire
